/* pipeCore.f */
source/pipePkg.sv
source/fetchDecode.sv
source/regFile.sv
source/executeStage.sv
source/memWriteback.sv
source/hazard.sv
source/pipeCore.sv
test/pipeCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := pipeCoreTb
FILELIST  := pipeCore.f
BUILDDIR  := obj_dir
LOG       := sim.log
PASSTEXT  := Result: PASSED
LINTFLAGS := --lint-only -Wall --timing
SIMFLAGS  := --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* test/pipeCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCoreTb import pipePkg::*; ();

  localparam int progLen      = 200;
  localparam int memWords     = 64;
  localparam int stallPercent = 8;
  localparam int stallPlanLen = 8192;
  // Stalls stay off until the first op has retired
  localparam int stallDelay   = 8;
  localparam int firstTimeout = 50;
  localparam int drainTimeout = 6000;
  localparam int idleCycles   = 20;
  // Loads and stores address through a register that is never written
  localparam regIdx    baseReg     = 4'd15;
  localparam instrWord bubbleInstr = 32'hF000_0000;

  logic      clk;
  logic      arstN;
  instrWord  fetchInstr;
  logic      iStall;
  logic      dStall;
  word       dataRData;
  word       fetchPc;
  memReq     dataReq;
  logic      retireValid;
  retireInfo retire;

  instrWord  imem [progLen];
  word       dmem [memWords];
  word       modelMem [memWords];
  word       modelRegs [numRegs];
  // Bit 1 is iStall, bit 0 is dStall
  logic [1:0] stallPlan [stallPlanLen];
  retireInfo expQ [$];

  int errorCount;
  int checkCount;
  int testCount;
  int failedTests;
  int cycleCount;
  int fetchCycle;
  int firstRetireCycle;
  int retiredCount;
  int expectedCount;
  int fwdOps;
  int loadUsePairs;
  int takenBranches;
  int notTakenBranches;
  bit fetchSeen;
  bit retireSeen;

  pipeCore pipeCore_inst (
    .clk, .arstN, .fetchInstr, .iStall, .dStall, .dataRData,
    .fetchPc, .dataReq, .retireValid, .retire
  );

  always #50 clk = ~clk;

  // Opcode 31:28, rd 27:24, rn 23:20, rm 19:16, imm 15:0
  function automatic instrWord encodeInstr(opcode op, regIdx rd, regIdx rn, regIdx rm,
                                           logic [15:0] imm);
    return {op, rd, rn, rm, imm};
  endfunction

  // rd and value mean nothing for stores and branches
  function automatic retireInfo maskUnused(retireInfo r);
    retireInfo m;
    m = r;
    if (!m.writesReg)
    begin
      m.rd    = '0;
      m.value = '0;
    end
    return m;
  endfunction

  function automatic string formatRetire(retireInfo r);
    return $sformatf("pc %h rd %0d wr %0b value %h", r.pc, r.rd, r.writesReg, r.value);
  endfunction

  task automatic checkRetire(input string name, input retireInfo expected,
                             input retireInfo actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Mismatch %s: expected %s, actual %s", name,
               formatRetire(expected), formatRetire(actual));
    end
  endtask

  task automatic checkWord(input string name, input word expected, input word actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore, input string detail);
    testCount++;
    if (errorCount == errorsBefore)
      $display("Test %s finished: ok %s", name, detail);
    else
    begin
      failedTests++;
      $display("Test %s finished: %0d errors %s", name, errorCount - errorsBefore, detail);
    end
  endtask

  // Dense register use, forward branches only, sixteen data words in play
  task automatic buildProgram();
    int          kind;
    regIdx       rd;
    regIdx       rn;
    regIdx       rm;
    logic [15:0] offset;
    for (int i = 0; i < progLen; i++)
    begin
      kind   = $urandom_range(0, 99);
      rd     = regIdx'($urandom_range(0, 6));
      rn     = regIdx'($urandom_range(0, 6));
      rm     = regIdx'($urandom_range(0, 6));
      offset = 16'($urandom_range(0, 15) * 4);
      if (kind < 20)
        imem[i] = encodeInstr(opMovi, rd, rn, rm, 16'($urandom));
      else if (kind < 60)
        imem[i] = encodeInstr(opcode'($urandom_range(0, 3)), rd, rn, rm, 16'h0000);
      else if (kind < 75)
        imem[i] = encodeInstr(opLdr, rd, baseReg, rm, offset);
      else if (kind < 88)
        imem[i] = encodeInstr(opStr, 4'd0, baseReg, rm, offset);
      else
        imem[i] = encodeInstr(opBnz, 4'd0, rn, rm, 16'($urandom_range(1, 4)));
    end
    for (int i = 0; i < memWords; i++)
    begin
      dmem[i]     = $urandom;
      modelMem[i] = dmem[i];
    end
    for (int i = 0; i < stallPlanLen; i++)
    begin
      stallPlan[i][1] = ($urandom_range(0, 99) < stallPercent);
      stallPlan[i][0] = ($urandom_range(0, 99) < stallPercent);
    end
  endtask

  // Architectural model, one instruction at a time in program order
  task automatic runModel();
    int        pc;
    int        nextPc;
    instrWord  ins;
    opcode     op;
    regIdx     rd;
    regIdx     rn;
    regIdx     rm;
    word       imm;
    word       addr;
    retireInfo exp;
    regIdx     lastRd;
    bit        lastWrites;
    bit        lastLoad;
    regIdx     olderRd;
    bit        olderWrites;
    pc          = 0;
    lastRd      = '0;
    lastWrites  = 1'b0;
    lastLoad    = 1'b0;
    olderRd     = '0;
    olderWrites = 1'b0;
    for (int r = 0; r < numRegs; r++)
      modelRegs[r] = '0;
    while (pc < progLen)
    begin
      ins    = imem[pc];
      op     = opcode'(ins[31:28]);
      rd     = ins[27:24];
      rn     = ins[23:20];
      rm     = ins[19:16];
      imm    = {{16{ins[15]}}, ins[15:0]};
      addr   = modelRegs[rn] + imm;
      nextPc = pc + 1;
      exp    = '0;
      exp.pc = word'(pc * 4);
      // Hazard cases the program reaches
      if ((op inside {opAdd, opSub, opAnd, opOrr}) &&
          ((lastWrites && (rn == lastRd || rm == lastRd)) ||
           (olderWrites && (rn == olderRd || rm == olderRd))))
        fwdOps++;
      if (lastLoad && (rn == lastRd || rm == lastRd))
        loadUsePairs++;
      exp.writesReg = op inside {opAdd, opSub, opAnd, opOrr, opMovi, opLdr};
      case (op)
        opAdd:  exp.value = modelRegs[rn] + modelRegs[rm];
        opSub:  exp.value = modelRegs[rn] - modelRegs[rm];
        opAnd:  exp.value = modelRegs[rn] & modelRegs[rm];
        opOrr:  exp.value = modelRegs[rn] | modelRegs[rm];
        opMovi: exp.value = imm;
        opLdr:  exp.value = modelMem[addr[7:2]];
        opStr:  modelMem[addr[7:2]] = modelRegs[rm];
        opBnz:
        begin
          // Offset counts words from the branch itself
          if (modelRegs[rn] != '0)
          begin
            nextPc = pc + int'(imm);
            takenBranches++;
          end
          else
            notTakenBranches++;
        end
        default:;
      endcase
      if (exp.writesReg)
      begin
        exp.rd        = rd;
        modelRegs[rd] = exp.value;
      end
      expQ.push_back(exp);
      olderRd     = lastRd;
      olderWrites = lastWrites;
      lastRd      = rd;
      lastWrites  = exp.writesReg;
      lastLoad    = (op == opLdr);
      pc          = nextPc;
    end
    expectedCount = expQ.size();
  endtask

  // Inputs change on the falling edge, away from the sampling edge
  always @(negedge clk)
  begin
    int fetchIdx;
    if (fetchSeen && (cycleCount >= fetchCycle + stallDelay))
    begin
      iStall = stallPlan[cycleCount % stallPlanLen][1];
      dStall = stallPlan[cycleCount % stallPlanLen][0];
    end
    fetchIdx = int'(fetchPc[31:2]);
    // A live-looking op during iStall must never be taken
    if (iStall)
      fetchInstr = encodeInstr(opMovi, 4'd0, 4'd0, 4'd0, 16'hdead);
    else if (fetchIdx < progLen)
      fetchInstr = imem[fetchIdx];
    else
      fetchInstr = bubbleInstr;
    if (dataReq.read && !dStall)
      dataRData = dmem[dataReq.addr[7:2]];
    else
      dataRData = 32'h0bad_0bad;
  end

  // Retirements, fetch timing and stores seen at the rising edge
  always @(posedge clk)
  begin
    if (arstN)
    begin
      if (!fetchSeen)
      begin
        fetchSeen  = 1'b1;
        fetchCycle = cycleCount;
      end
      if (retireValid)
      begin
        if (!retireSeen)
        begin
          retireSeen       = 1'b1;
          firstRetireCycle = cycleCount;
        end
        retiredCount++;
        if (expQ.size() == 0)
        begin
          errorCount++;
          $display("Unexpected retirement at pc %h after the program finished", retire.pc);
        end
        else
          checkRetire("retireStream", expQ.pop_front(), maskUnused(retire));
      end
      // Store lands when the data side is not stalled
      if (dataReq.write && !dStall)
        dmem[dataReq.addr[7:2]] = dataReq.wdata;
    end
    cycleCount++;
  end

  initial
  begin
    int startErrors;
    int waited;
    clk              = 1'b0;
    arstN            = 1'b0;
    iStall           = 1'b0;
    dStall           = 1'b0;
    fetchInstr       = bubbleInstr;
    dataRData        = '0;
    errorCount       = 0;
    checkCount       = 0;
    testCount        = 0;
    failedTests      = 0;
    cycleCount       = 0;
    fetchCycle       = 0;
    firstRetireCycle = 0;
    retiredCount     = 0;
    fwdOps           = 0;
    loadUsePairs     = 0;
    takenBranches    = 0;
    notTakenBranches = 0;
    fetchSeen        = 1'b0;
    retireSeen       = 1'b0;
    void'($urandom(32'h6e11fabe));
    buildProgram();
    runModel();

    // Nothing reaches memory or writeback for three cycles after reset
    startErrors = errorCount;
    repeat (4) @(posedge clk);
    checkWord("reset", '0, fetchPc);
    checkWord("reset", '0, word'({retireValid, dataReq.read, dataReq.write}));
    @(negedge clk);
    arstN = 1'b1;
    @(posedge clk);
    checkWord("reset", '0, fetchPc);
    repeat (3)
    begin
      checkWord("reset", '0, word'({retireValid, dataReq.read, dataReq.write}));
      @(posedge clk);
    end
    reportTest("reset", startErrors, "");

    // Fetch to retire is four cycles without stalls
    startErrors = errorCount;
    waited      = 0;
    while (!retireSeen && waited < firstTimeout)
    begin
      @(negedge clk);
      waited++;
    end
    if (!retireSeen)
    begin
      errorCount++;
      $display("Timeout waiting for the first retirement");
    end
    else
      checkWord("latency", word'(fetchCycle + 4), word'(firstRetireCycle));
    reportTest("latency", startErrors, "");

    // Whole program under random stalls
    startErrors = errorCount;
    if (fwdOps == 0 || loadUsePairs == 0 || takenBranches == 0 || notTakenBranches == 0)
    begin
      errorCount++;
      $display("Program misses a hazard case");
    end
    waited = 0;
    while (expQ.size() != 0 && waited < drainTimeout)
    begin
      @(negedge clk);
      waited++;
    end
    if (expQ.size() != 0)
    begin
      errorCount++;
      $display("Timeout with %0d retirements still outstanding", expQ.size());
    end
    // Flushed or repeated ops would show up here
    repeat (idleCycles) @(negedge clk);
    checkWord("retireStream count", word'(expectedCount), word'(retiredCount));
    reportTest("retireStream", startErrors,
               $sformatf("(%0d retired, %0d forwarded, %0d load-use, %0d taken, %0d not taken)",
                         retiredCount, fwdOps, loadUsePairs, takenBranches, notTakenBranches));

    // Stores checked by what they leave behind
    startErrors = errorCount;
    for (int i = 0; i < memWords; i++)
      checkWord($sformatf("finalMemory[%0d]", i), modelMem[i], dmem[i]);
    reportTest("finalMemory", startErrors, "");

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             testCount, failedTests, checkCount, errorCount);
    if (errorCount == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* source/pipeCore.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCore import pipePkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  instrWord  fetchInstr,
  input  logic      iStall,
  input  logic      dStall,
  input  word       dataRData,
  output word       fetchPc,
  output memReq     dataReq,
  output logic      retireValid,
  output retireInfo retire
);

  stageCtl   ctl;
  hazardInfo info;
  forwardSel forwardAE;
  forwardSel forwardBE;
  decodedOp  opD;
  decodedOp  opE;
  regIdx     rdAddrA;
  regIdx     rdAddrB;
  word       rdDataA;
  word       rdDataB;
  word       branchTarget;
  logic      branchTakenE;
  word       aluResultE;
  word       storeDataE;
  word       resultM;
  word       resultW;
  regIdx     rdM;
  logic      writesM;
  logic      wrEn;
  regIdx     wrAddr;
  word       wrData;

  // Hazard view gathered from every stage
  assign info = '{
    rnD:          rdAddrA,
    rmD:          rdAddrB,
    rnE:          opE.rn,
    rmE:          opE.rm,
    rdE:          opE.rd,
    memToRegE:    opE.valid & opE.memToReg,
    rdM:          rdM,
    writesM:      writesM,
    rdW:          retire.rd,
    writesW:      retire.writesReg,
    branchTakenE: branchTakenE
  };

  fetchDecode fetchDecode_inst (
    .clk, .arstN, .fetchInstr, .ctl, .branchTarget,
    .rdDataA, .rdDataB, .fetchPc, .rdAddrA, .rdAddrB, .opD
  );

  regFile regFile_inst (
    .clk, .arstN, .rdAddrA, .rdAddrB, .wrEn, .wrAddr, .wrData, .rdDataA, .rdDataB
  );

  executeStage executeStage_inst (
    .clk, .arstN, .opD, .operandA(rdDataA), .operandB(rdDataB), .ctl,
    .forwardAE, .forwardBE, .resultM, .resultW,
    .opE, .aluResultE, .storeDataE, .branchTarget, .branchTakenE
  );

  memWriteback memWriteback_inst (
    .clk, .arstN, .opE, .aluResultE, .storeDataE, .ctl, .dataRData,
    .req(dataReq), .resultM, .resultW, .rdM, .writesM,
    .wrEn, .wrAddr, .wrData, .retireValid, .retire
  );

  hazard hazard_inst (
    .clk, .arstN, .info, .iStall, .dStall, .ctl, .forwardAE, .forwardBE
  );

endmodule

`default_nettype wire

/* source/hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard import pipePkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  hazardInfo info,
  input  logic      iStall,
  input  logic      dStall,
  output stageCtl   ctl,
  output forwardSel forwardAE,
  output forwardSel forwardBE
);

  logic memStall;
  logic loadUse;

  assign memStall = iStall | dStall;

  // Memory stage wins over writeback because it holds the newer value
  always_comb
  begin
    if ((info.rnE == info.rdM) && info.writesM)
      forwardAE = fwdFromM;
    else if ((info.rnE == info.rdW) && info.writesW)
      forwardAE = fwdFromW;
    else
      forwardAE = fwdNone;

    if ((info.rmE == info.rdM) && info.writesM)
      forwardBE = fwdFromM;
    else if ((info.rmE == info.rdW) && info.writesW)
      forwardBE = fwdFromW;
    else
      forwardBE = fwdNone;
  end

  // Decode reads what the load in execute is about to fetch
  // Nothing moves during a memory freeze, so the check waits for it to end
  assign loadUse = info.memToRegE & ~memStall &
                   ((info.rdE == info.rnD) | (info.rdE == info.rmD));

  // Stalled stages hold
  // The stage after a load-use gets a bubble
  // Taken branch kills the two younger ops
  always_comb
  begin
    ctl.stallF = loadUse | memStall;
    ctl.stallD = loadUse | memStall;
    ctl.flushD = info.branchTakenE | iStall;
    ctl.flushE = loadUse | info.branchTakenE;
    ctl.stallE = memStall;
    ctl.stallM = memStall;
    ctl.stallW = memStall;
    ctl.flushW = memStall;
  end

  // Execute never gets a bubble while it is frozen
  assert property (@(posedge clk) disable iff (!arstN)
    !(ctl.flushE && ctl.stallE));

  // A writeback forward names an op that left memory writing a register
  assert property (@(posedge clk) disable iff (!arstN)
    ((forwardAE == fwdFromW) || (forwardBE == fwdFromW)) && !$past(ctl.stallW)
    |-> $past(info.writesM));

endmodule

`default_nettype wire

/* source/memWriteback.sv */
`timescale 1ns/1ps
`default_nettype none

module memWriteback import pipePkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  decodedOp  opE,
  input  word       aluResultE,
  input  word       storeDataE,
  input  stageCtl   ctl,
  input  word       dataRData,
  output memReq     req,
  output word       resultM,
  output word       resultW,
  output regIdx     rdM,
  output logic      writesM,
  output logic      wrEn,
  output regIdx     wrAddr,
  output word       wrData,
  output logic      retireValid,
  output retireInfo retire
);

  decodedOp opM;
  decodedOp opW;
  word      aluM;
  word      storeM;
  word      valueM;
  word      valueW;

  // Execute/memory register
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      opM <= '0;
    else if (!ctl.stallM)
      opM <= opE;
  end

  always_ff @(posedge clk)
  begin
    if (!ctl.stallM)
    begin
      aluM   <= aluResultE;
      storeM <= storeDataE;
    end
  end

  // Request stays up while dStall holds the stage
  assign req = '{
    addr:  aluM,
    wdata: storeM,
    read:  opM.valid & opM.memToReg,
    write: opM.valid & opM.memWrite
  };

  // Load data or ALU result
  assign valueM = opM.memToReg ? dataRData : aluM;

  // Memory/writeback register
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      opW <= '0;
    else if (!ctl.stallW)
      opW <= opM;
  end

  always_ff @(posedge clk)
  begin
    if (!ctl.stallW)
      valueW <= valueM;
  end

  // Forwarding sources
  assign resultM = aluM;
  assign resultW = valueW;
  assign rdM     = opM.rd;
  assign writesM = opM.valid & opM.writesReg;

  // Writeback is held off while frozen
  // The op stays in W and completes once the freeze lifts
  assign retireValid = opW.valid & ~ctl.flushW;
  assign wrEn        = retireValid & opW.writesReg;
  assign wrAddr      = opW.rd;
  assign wrData      = valueW;

  assign retire = '{
    pc:        opW.pc,
    rd:        opW.rd,
    writesReg: opW.valid & opW.writesReg,
    value:     valueW
  };

  // Decode never marks one op as both load and store
  assert property (@(posedge clk) disable iff (!arstN)
    !(req.read && req.write));

endmodule

`default_nettype wire

/* source/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage import pipePkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  decodedOp  opD,
  input  word       operandA,
  input  word       operandB,
  input  stageCtl   ctl,
  input  forwardSel forwardAE,
  input  forwardSel forwardBE,
  input  word       resultM,
  input  word       resultW,
  output decodedOp  opE,
  output word       aluResultE,
  output word       storeDataE,
  output word       branchTarget,
  output logic      branchTakenE
);

  decodedOp nextE;
  word      regA;
  word      regB;
  word      srcA;
  word      srcB;

  // Flush turns the incoming op into a bubble
  always_comb
  begin
    nextE       = opD;
    nextE.valid = opD.valid & ~ctl.flushE;
  end

  // Decode/execute register
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      opE <= '0;
    else if (!ctl.stallE)
      opE <= nextE;
  end

  // Register file values sampled with the op
  always_ff @(posedge clk)
  begin
    if (!ctl.stallE)
    begin
      regA <= operandA;
      regB <= operandB;
    end
  end

  // Operand selection, memory stage is the newer value
  always_comb
  begin
    case (forwardAE)
      fwdFromM: srcA = resultM;
      fwdFromW: srcA = resultW;
      default:  srcA = regA;
    endcase
    case (forwardBE)
      fwdFromM: srcB = resultM;
      fwdFromW: srcB = resultW;
      default:  srcB = regB;
    endcase
  end

  always_comb
  begin
    case (opE.op)
      opAdd:        aluResultE = srcA + srcB;
      opSub:        aluResultE = srcA - srcB;
      opAnd:        aluResultE = srcA & srcB;
      opOrr:        aluResultE = srcA | srcB;
      opMovi:       aluResultE = opE.imm;
      // Load and store address
      opLdr, opStr: aluResultE = srcA + opE.imm;
      default:      aluResultE = '0;
    endcase
  end

  // Store data comes from rm
  assign storeDataE = srcB;

  // Offset counts words
  assign branchTarget = opE.pc + {opE.imm[29:0], 2'b00};

  // Held back while frozen, the redirect happens once the stage moves
  assign branchTakenE = opE.valid & opE.isBranch & (srcA != '0) & ~ctl.stallE;

  // A memory-stage forward always names an op that left here writing a register
  assert property (@(posedge clk) disable iff (!arstN)
    ((forwardAE == fwdFromM) || (forwardBE == fwdFromM)) && !$past(ctl.stallM)
    |-> $past(opE.valid && opE.writesReg));

endmodule

`default_nettype wire

/* source/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import pipePkg::*; (
  input  logic  clk,
  input  logic  arstN,
  input  regIdx rdAddrA,
  input  regIdx rdAddrB,
  input  logic  wrEn,
  input  regIdx wrAddr,
  input  word   wrData,
  output word   rdDataA,
  output word   rdDataB
);

  word regs [numRegs];

  // Written from writeback on the rising edge
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < numRegs; i++)
        regs[i] <= '0;
    end
    else if (wrEn)
      regs[wrAddr] <= wrData;
  end

  // Asynchronous reads
  // A write in the same cycle reaches decode through the bypass
  assign rdDataA = (wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
  assign rdDataB = (wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

/* source/fetchDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchDecode import pipePkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  instrWord fetchInstr,
  input  stageCtl  ctl,
  input  word      branchTarget,
  input  word      rdDataA,
  input  word      rdDataB,
  output word      fetchPc,
  output regIdx    rdAddrA,
  output regIdx    rdAddrB,
  output decodedOp opD
);

  word      pcF;
  word      pcD;
  instrWord instrD;
  logic     validD;
  opcode    opField;

  assign fetchPc = pcF;

  // Next sequential word, or the branch target on a redirect
  // flushD while fetch runs can only come from a taken branch
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      pcF <= '0;
    else if (!ctl.stallF)
      pcF <= ctl.flushD ? branchTarget : pcF + 32'd4;
  end

  // Fetch/decode register, valid bit only
  // A flush only lands when the stage is free to move
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      validD <= 1'b0;
    else if (!ctl.stallD)
      validD <= !ctl.flushD;
  end

  // Instruction and pc ride along with the valid bit
  always_ff @(posedge clk)
  begin
    if (!ctl.stallD)
    begin
      instrD <= fetchInstr;
      pcD    <= pcF;
    end
  end

  assign opField = opcode'(instrD[31:28]);

  // Register file addresses come straight from the instruction fields
  assign rdAddrA = instrD[23:20];
  assign rdAddrB = instrD[19:16];

  always_comb
  begin
    opD       = '0;
    opD.valid = validD;
    opD.op    = opField;
    opD.rd    = instrD[27:24];
    opD.rn    = rdAddrA;
    opD.rm    = rdAddrB;
    // Sign extend the low field
    opD.imm   = {{(32 - immWidth){instrD[immWidth-1]}}, instrD[immWidth-1:0]};
    opD.pc    = pcD;
    case (opField)
      opAdd, opSub, opAnd, opOrr, opMovi:
        opD.writesReg = 1'b1;
      opLdr:
      begin
        opD.writesReg = 1'b1;
        opD.memToReg  = 1'b1;
      end
      opStr:
        opD.memWrite = 1'b1;
      opBnz:
        opD.isBranch = 1'b1;
      // Unused code becomes a bubble
      default:
        opD.valid = 1'b0;
    endcase
  end

  // Operands handed to execute for a live op are never unknown
  assert property (@(posedge clk) disable iff (!arstN)
    opD.valid |-> !$isunknown({rdDataA, rdDataB}));

endmodule

`default_nettype wire

/* source/pipePkg.sv */
`default_nettype none

package pipePkg;

  // Register file depth
  localparam int numRegs  = 16;
  // Sign-extended immediate and branch offset width
  localparam int immWidth = 16;

  typedef logic [31:0]                word;
  typedef logic [31:0]                instrWord;
  typedef logic [$clog2(numRegs)-1:0] regIdx;

  // Instruction fields are opcode 31:28, rd 27:24, rn 23:20, rm 19:16, imm 15:0
  // BNZ tests rn and branches by imm words relative to its own pc
  // Codes 8 to 15 are unused and decode as a bubble
  typedef enum logic [3:0] {
    opAdd  = 4'h0,
    opSub  = 4'h1,
    opAnd  = 4'h2,
    opOrr  = 4'h3,
    opMovi = 4'h4,
    opLdr  = 4'h5,
    opStr  = 4'h6,
    opBnz  = 4'h7
  } opcode;

  // Operand source in execute
  typedef enum logic [1:0] {
    fwdNone  = 2'b00,
    fwdFromW = 2'b01,
    fwdFromM = 2'b10
  } forwardSel;

  typedef struct packed {
    logic  valid;
    opcode op;
    regIdx rd;
    regIdx rn;
    regIdx rm;
    logic  writesReg;
    logic  memToReg;
    logic  memWrite;
    logic  isBranch;
    word   imm;
    word   pc;
  } decodedOp;

  // Register numbers and write flags seen by the hazard unit
  typedef struct packed {
    regIdx rnD;
    regIdx rmD;
    regIdx rnE;
    regIdx rmE;
    regIdx rdE;
    logic  memToRegE;
    regIdx rdM;
    logic  writesM;
    regIdx rdW;
    logic  writesW;
    logic  branchTakenE;
  } hazardInfo;

  typedef struct packed {
    logic stallF;
    logic stallD;
    logic flushD;
    logic flushE;
    logic stallE;
    logic stallM;
    logic stallW;
    logic flushW;
  } stageCtl;

  typedef struct packed {
    word   pc;
    regIdx rd;
    logic  writesReg;
    word   value;
  } retireInfo;

  typedef struct packed {
    word  addr;
    word  wdata;
    logic read;
    logic write;
  } memReq;

endpackage

`default_nettype wire
